// File: sources.f
verilog/common_pkg.sv
verilog/wb_sram_target.sv
verilog/wb_demux.sv
verilog/arbiter.sv
verilog/pet_bus_top.sv
verif/pet_bus_assert.sv
verif/pet_bus_tb.sv

// File: Bender.yml
package:
  name: pet_bus

sources:
  - files:
      - verilog/common_pkg.sv
      - verilog/wb_sram_target.sv
      - verilog/wb_demux.sv
      - verilog/arbiter.sv
      - verilog/pet_bus_top.sv
  - target: test
    files:
      - verif/pet_bus_assert.sv
      - verif/pet_bus_tb.sv

// File: verif/pet_bus_tb.sv
// Testbench for the PET bus subsystem with random controllers, memory model and slot model
`timescale 1ns/1ns
`default_nettype none

module pet_bus_tb;
    import common_pkg::*;

    localparam int CLK_DIV        = 8;      // Same as the DUT defaults
    localparam int MEM_ADDR_BITS  = 10;
    localparam int LOW_ADDR_BITS  = 5;      // Small pool so both controllers share bytes
    localparam int N_TRANS        = 40;     // Accepted requests per controller
    localparam int TIMEOUT_CYCLES = N_TRANS * 8 * CLK_DIV * 4;

    typedef struct packed {
        logic  is_read;
        logic  known;                       // Byte written before, read value defined
        data_t data;
    } exp_t;

    logic                        wb_clock = 1'b0;
    logic                        arst_n;
    logic [1:0]                  req_on;    // Cycle and strobe, index 0 = video, 1 = SPI
    logic [1:0]                  we_r;
    wb_addr_t [1:0]              addr_r;
    data_t [1:0]                 dout_r;
    wire  [1:0]                  stall_s;
    wire  [1:0]                  ack_s;
    wire  [1:0][DATA_WIDTH-1:0]  din_s;
    wire                         cpu_grant;

    integer     seed = 64067;
    int         cycle_cnt;
    int         edges_since_rst;
    logic       started;
    logic       pulse_prev;
    logic       window_m;                   // Model bus window
    slot_e      tb_slot;
    logic [1:0] acc_flag;                   // Request accepted at the coming edge
    int         acc_cnt [2];
    logic       all_done;
    data_t      mem_model [2**MEM_ADDR_BITS];
    logic       written   [2**MEM_ADDR_BITS];
    exp_t       video_q [$];
    exp_t       spi_q [$];

    int ack_errs;
    int data_errs;
    int slot_errs;
    int grant_errs;
    int reset_errs;
    int timeout_errs;

    pet_bus_top dut_i (
        .wb_clock_i     (wb_clock),
        .arst_n_i       (arst_n),
        .spi1_addr_i    (addr_r[1]),
        .spi1_dout_i    (dout_r[1]),
        .spi1_din_o     (din_s[1]),
        .spi1_we_i      (we_r[1]),
        .spi1_cycle_i   (req_on[1]),
        .spi1_strobe_i  (req_on[1]),
        .spi1_stall_o   (stall_s[1]),
        .spi1_ack_o     (ack_s[1]),
        .video_addr_i   (addr_r[0]),
        .video_dout_i   (dout_r[0]),
        .video_din_o    (din_s[0]),
        .video_we_i     (we_r[0]),
        .video_cycle_i  (req_on[0]),
        .video_strobe_i (req_on[0]),
        .video_stall_o  (stall_s[0]),
        .video_ack_o    (ack_s[0]),
        .cpu_grant_en_o (cpu_grant)
    );

    initial begin
        forever #10 wb_clock = ~wb_clock;
    end

    function automatic string port_name(input int c);
        return (c == 0) ? "video" : "spi1";
    endfunction

    function automatic logic slot_owner_ok(input int c);
        if (c == 0) begin
            return window_m && (tb_slot == SLOT_VIDEO_1 || tb_slot == SLOT_VIDEO_2
                                || tb_slot == SLOT_VIDEO_3 || tb_slot == SLOT_VIDEO_4);
        end
        return window_m && (tb_slot == SLOT_SPI_1 || tb_slot == SLOT_SPI_2);
    endfunction

    task report_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    endtask

    task issue_request(input int c);
        wb_addr_t addr;
        addr = wb_addr_t'($random(seed));
        addr[MEM_ADDR_BITS-1:LOW_ADDR_BITS] = '0;   // Bits above the RAM stay random
        req_on[c] <= 1'b1;
        addr_r[c] <= addr;
        dout_r[c] <= data_t'($random(seed));
        we_r[c]   <= ($random(seed) & 1) != 0;
    endtask

    // Wheel resets to SPI_2, steps on each pulse, window is the cycle after the pulse
    task update_slot_model();
        if (!arst_n) begin
            started         = 1'b0;
            edges_since_rst = 0;
            pulse_prev      = 1'b0;
            window_m        = 1'b0;
            tb_slot         = SLOT_SPI_2;
        end else begin
            if (started) begin
                edges_since_rst++;
            end else begin
                started = 1'b1;
            end
            window_m = pulse_prev;
            if (pulse_prev) begin
                tb_slot = slot_e'((int'(tb_slot) + 1) % 8);
            end
            pulse_prev = (edges_since_rst > 0) && (edges_since_rst % CLK_DIV == 0);
        end
    endtask

    task check_grant_and_reset();
        logic exp_grant;
        exp_grant = window_m && (tb_slot == SLOT_CPU_1 || tb_slot == SLOT_CPU_2);
        assert (cpu_grant === exp_grant) else begin
            grant_errs++;
            report_mismatch("cpu_grant_en_o", cpu_grant, exp_grant);
        end
        // Up to the first window both controllers stay stalled
        if (!arst_n || edges_since_rst <= CLK_DIV) begin
            for (int c = 0; c < 2; c++) begin
                assert (stall_s[c] === 1'b1) else begin
                    reset_errs++;
                    report_mismatch({port_name(c), "_stall_o"}, stall_s[c], 1'b1);
                end
            end
        end
    endtask

    task track_port(input int c);
        logic                     accepted;
        exp_t                     entry;
        logic [MEM_ADDR_BITS-1:0] idx;
        accepted = (req_on[c] & ~stall_s[c]) === 1'b1;
        assert (ack_s[c] === acc_flag[c]) else begin
            ack_errs++;
            report_mismatch({port_name(c), "_ack_o"}, ack_s[c], acc_flag[c]);
        end
        if (ack_s[c] === 1'b1 && ((c == 0) ? video_q.size() : spi_q.size()) > 0) begin
            if (c == 0) entry = video_q.pop_front();
            else entry = spi_q.pop_front();
            if (entry.is_read && entry.known) begin
                assert (din_s[c] === entry.data) else begin
                    data_errs++;
                    report_mismatch({port_name(c), "_din_o"}, din_s[c], entry.data);
                end
            end
        end
        if (accepted) begin
            assert (slot_owner_ok(c)) else begin
                slot_errs++;
                $display("%s request accepted at %0t outside a window of its own slot (%s)",
                         port_name(c), $time, tb_slot.name());
            end
            idx           = addr_r[c][MEM_ADDR_BITS-1:0];  // RAM ignores upper bits
            entry.is_read = !we_r[c];
            entry.known   = written[idx];
            entry.data    = mem_model[idx];
            if (c == 0) video_q.push_back(entry);
            else spi_q.push_back(entry);
            if (we_r[c]) begin
                mem_model[idx] = dout_r[c];
                written[idx]   = 1'b1;
            end
            acc_cnt[c]++;
        end
        acc_flag[c] = accepted;
    endtask

    // Outputs are stable at the falling edge
    always @(negedge wb_clock) begin
        update_slot_model();
        check_grant_and_reset();
        track_port(0);
        track_port(1);
        all_done = (acc_cnt[0] == N_TRANS) && (acc_cnt[1] == N_TRANS)
                   && (video_q.size() == 0) && (spi_q.size() == 0) && (acc_flag == 2'b00);
    end

    // Requests held until accepted, then a new one or an idle cycle
    always @(posedge wb_clock) begin
        if (arst_n) begin
            for (int c = 0; c < 2; c++) begin
                if (!req_on[c] || acc_flag[c]) begin
                    if (acc_cnt[c] < N_TRANS && ($random(seed) & 3) != 0) begin
                        issue_request(c);
                    end else begin
                        req_on[c] <= 1'b0;
                    end
                end
            end
        end
    end

    initial begin
        arst_n       = 1'b0;
        req_on       = '0;
        we_r         = '0;
        addr_r       = '0;
        dout_r       = '0;
        acc_flag     = '0;
        acc_cnt[0]   = 0;
        acc_cnt[1]   = 0;
        all_done     = 1'b0;
        cycle_cnt    = 0;
        ack_errs     = 0;
        data_errs    = 0;
        slot_errs    = 0;
        grant_errs   = 0;
        reset_errs   = 0;
        timeout_errs = 0;
        for (int i = 0; i < 2**MEM_ADDR_BITS; i++) begin
            written[i] = 1'b0;
        end
        repeat (10) @(posedge wb_clock);
        arst_n <= 1'b1;
        while (!all_done && cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge wb_clock);
            cycle_cnt++;
        end
        if (!all_done) begin
            timeout_errs++;
            $display("Timeout after %0d cycles, video accepted %0d and SPI %0d of %0d requests",
                     cycle_cnt, acc_cnt[0], acc_cnt[1], N_TRANS);
        end
        $display("Errors: ack %0d, read data %0d, slot %0d, cpu grant %0d, reset %0d, timeout %0d",
                 ack_errs, data_errs, slot_errs, grant_errs, reset_errs, timeout_errs);
        if (ack_errs + data_errs + slot_errs + grant_errs + reset_errs + timeout_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Arbiter sees both controllers, the bus and the CPU grant
    bind arbiter pet_bus_assert u_bus_assert (
        .wb_clock_i     (wb_clock_i),
        .arst_n_i       (arst_n_i),
        .wb_cycle_i     (wb_cycle_o),
        .wb_strobe_i    (wb_strobe_o),
        .wb_stall_i     (wb_stall_i),
        .wb_ack_i       (wb_ack_i),
        .video_cycle_i  (video_cycle_i),
        .video_strobe_i (video_strobe_i),
        .video_stall_i  (video_stall_o),
        .video_ack_i    (video_ack_o),
        .video_addr_i   (video_addr_i),
        .video_dout_i   (video_dout_i),
        .video_we_i     (video_we_i),
        .spi1_cycle_i   (spi1_cycle_i),
        .spi1_strobe_i  (spi1_strobe_i),
        .spi1_stall_i   (spi1_stall_o),
        .spi1_ack_i     (spi1_ack_o),
        .spi1_addr_i    (spi1_addr_i),
        .spi1_dout_i    (spi1_dout_i),
        .spi1_we_i      (spi1_we_i),
        .cpu_grant_en_i (cpu_grant_en_o)
    );

endmodule

`default_nettype wire

// File: verif/pet_bus_assert.sv
// Concurrent assertions on the arbiter's Wishbone handshake, controller requests and CPU grant
`timescale 1ns/1ns
`default_nettype none

module pet_bus_assert (
    input  logic                  wb_clock_i,
    input  logic                  arst_n_i,

    // Shared bus as seen by the arbiter
    input  logic                  wb_cycle_i,
    input  logic                  wb_strobe_i,
    input  logic                  wb_stall_i,
    input  logic                  wb_ack_i,

    input  logic                  video_cycle_i,
    input  logic                  video_strobe_i,
    input  logic                  video_stall_i,
    input  logic                  video_ack_i,
    input  common_pkg::wb_addr_t  video_addr_i,
    input  common_pkg::data_t     video_dout_i,
    input  logic                  video_we_i,

    input  logic                  spi1_cycle_i,
    input  logic                  spi1_strobe_i,
    input  logic                  spi1_stall_i,
    input  logic                  spi1_ack_i,
    input  common_pkg::wb_addr_t  spi1_addr_i,
    input  common_pkg::data_t     spi1_dout_i,
    input  logic                  spi1_we_i,

    input  logic                  cpu_grant_en_i
);

    logic bus_accept;
    logic video_accept;
    logic spi1_accept;

    assign bus_accept   = wb_cycle_i & wb_strobe_i & ~wb_stall_i;
    assign video_accept = video_cycle_i & video_strobe_i & ~video_stall_i;
    assign spi1_accept  = spi1_cycle_i & spi1_strobe_i & ~spi1_stall_i;

    // Ack only in the cycle after an accepted request
    ack_follows_accept: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        wb_ack_i |-> $past(bus_accept))
        else $error("Bus ack without an accepted request in the cycle before");

    // Acks reach only the controller accepted in the cycle before
    ack_one_owner: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        !(video_ack_i && spi1_ack_i)
        && (video_ack_i == $past(video_accept)) && (spi1_ack_i == $past(spi1_accept)))
        else $error("Controller ack does not match its own request accepted the cycle before");

    video_hold: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        video_cycle_i && video_strobe_i && video_stall_i |=>
            video_cycle_i && video_strobe_i && $stable(video_addr_i)
            && $stable(video_dout_i) && $stable(video_we_i))
        else $error("Video request changed while stalled");

    spi1_hold: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        spi1_cycle_i && spi1_strobe_i && spi1_stall_i |=>
            spi1_cycle_i && spi1_strobe_i && $stable(spi1_addr_i)
            && $stable(spi1_dout_i) && $stable(spi1_we_i))
        else $error("SPI request changed while stalled");

    // CPU slots never carry bus traffic
    grant_idle_bus: assert property (@(posedge wb_clock_i) disable iff (!arst_n_i)
        !(cpu_grant_en_i && bus_accept))
        else $error("Bus request accepted while the CPU grant is high");

endmodule

`default_nettype wire

// File: verilog/pet_bus_top.sv
// Top level joining the slot arbiter and the Wishbone RAM target
`timescale 1ns/1ns
`default_nettype none

module pet_bus_top #(
    parameter int CLK_DIV       = 8,
    parameter int WAIT_STATES   = 1,
    parameter int MEM_ADDR_BITS = 10
) (
    input  logic                  wb_clock_i,
    input  logic                  arst_n_i,

    // SPI bridge controller
    input  common_pkg::wb_addr_t  spi1_addr_i,
    input  common_pkg::data_t     spi1_dout_i,
    output common_pkg::data_t     spi1_din_o,
    input  logic                  spi1_we_i,
    input  logic                  spi1_cycle_i,
    input  logic                  spi1_strobe_i,
    output logic                  spi1_stall_o,
    output logic                  spi1_ack_o,

    // Video fetch controller
    input  common_pkg::wb_addr_t  video_addr_i,
    input  common_pkg::data_t     video_dout_i,
    output common_pkg::data_t     video_din_o,
    input  logic                  video_we_i,
    input  logic                  video_cycle_i,
    input  logic                  video_strobe_i,
    output logic                  video_stall_o,
    output logic                  video_ack_o,

    output logic                  cpu_grant_en_o   // CPU may use the bus this cycle
);
    import common_pkg::*;

    // Internal Wishbone bus
    wb_addr_t wb_addr;
    data_t    wb_dout;
    data_t    wb_din;
    logic     wb_we;
    logic     wb_cycle;
    logic     wb_strobe;
    logic     wb_stall;
    logic     wb_ack;

    arbiter #(
        .CLK_DIV (CLK_DIV)
    ) u_arbiter (
        .wb_clock_i     (wb_clock_i),
        .arst_n_i       (arst_n_i),
        .spi1_addr_i    (spi1_addr_i),
        .spi1_dout_i    (spi1_dout_i),
        .spi1_din_o     (spi1_din_o),
        .spi1_we_i      (spi1_we_i),
        .spi1_cycle_i   (spi1_cycle_i),
        .spi1_strobe_i  (spi1_strobe_i),
        .spi1_stall_o   (spi1_stall_o),
        .spi1_ack_o     (spi1_ack_o),
        .video_addr_i   (video_addr_i),
        .video_dout_i   (video_dout_i),
        .video_din_o    (video_din_o),
        .video_we_i     (video_we_i),
        .video_cycle_i  (video_cycle_i),
        .video_strobe_i (video_strobe_i),
        .video_stall_o  (video_stall_o),
        .video_ack_o    (video_ack_o),
        .wb_addr_o      (wb_addr),
        .wb_dout_o      (wb_dout),
        .wb_din_i       (wb_din),
        .wb_we_o        (wb_we),
        .wb_cycle_o     (wb_cycle),
        .wb_strobe_o    (wb_strobe),
        .wb_stall_i     (wb_stall),
        .wb_ack_i       (wb_ack),
        .cpu_grant_en_o (cpu_grant_en_o)
    );

    wb_sram_target #(
        .WAIT_STATES   (WAIT_STATES),
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_sram (
        .wb_clock_i  (wb_clock_i),
        .arst_n_i    (arst_n_i),
        .wb_cycle_i  (wb_cycle),
        .wb_strobe_i (wb_strobe),
        .wb_addr_i   (wb_addr),
        .wb_dout_i   (wb_dout),
        .wb_we_i     (wb_we),
        .wb_din_o    (wb_din),
        .wb_stall_o  (wb_stall),
        .wb_ack_o    (wb_ack)
    );

endmodule

`default_nettype wire

// File: verilog/arbiter.sv
// Slot arbiter with clock-enable divider, slot wheel, grant decode and demux instance
`timescale 1ns/1ns
`default_nettype none

module arbiter #(
    parameter int CLK_DIV = 8                  // wb_clock_i cycles per wheel step
) (
    input  logic                     wb_clock_i,
    input  logic                     arst_n_i,

    // SPI bridge controller
    input  common_pkg::wb_addr_t     spi1_addr_i,
    input  common_pkg::data_t        spi1_dout_i,
    output common_pkg::data_t        spi1_din_o,
    input  logic                     spi1_we_i,
    input  logic                     spi1_cycle_i,
    input  logic                     spi1_strobe_i,
    output logic                     spi1_stall_o,
    output logic                     spi1_ack_o,

    // Video fetch controller
    input  common_pkg::wb_addr_t     video_addr_i,
    input  common_pkg::data_t        video_dout_i,
    output common_pkg::data_t        video_din_o,
    input  logic                     video_we_i,
    input  logic                     video_cycle_i,
    input  logic                     video_strobe_i,
    output logic                     video_stall_o,
    output logic                     video_ack_o,

    // Shared Wishbone bus
    output common_pkg::wb_addr_t     wb_addr_o,
    output common_pkg::data_t        wb_dout_o,
    input  common_pkg::data_t        wb_din_i,
    output logic                     wb_we_o,
    output logic                     wb_cycle_o,
    output logic                     wb_strobe_o,
    input  logic                     wb_stall_i,
    input  logic                     wb_ack_i,

    output logic                     cpu_grant_en_o
);
    import common_pkg::*;

    localparam int DIV_BITS = $clog2(CLK_DIV);
    localparam logic [DIV_BITS-1:0] DIV_LAST = DIV_BITS'(CLK_DIV - 1);

    logic [DIV_BITS-1:0] div_cnt;
    logic                clk8_en;              // One-cycle pulse every CLK_DIV cycles
    logic                clk8_en_delay;        // Bus window, one cycle after the pulse
    slot_e               slot;

    logic video_grant;
    logic cpu_grant;
    logic spi1_grant;
    logic wbc_sel;
    logic wb_en;

    // Clock-enable divider
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            div_cnt <= '0;
            clk8_en <= 1'b0;
        end else if (div_cnt == DIV_LAST) begin
            div_cnt <= '0;
            clk8_en <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            clk8_en <= 1'b0;
        end
    end

    // Slot wheel steps on each pulse, window opens the cycle after
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slot          <= SLOT_SPI_2;
            clk8_en_delay <= 1'b0;
        end else begin
            clk8_en_delay <= clk8_en;
            if (clk8_en) begin
                slot <= slot_e'(3'(slot) + 3'd1);   // Wraps from SPI_2 back to VIDEO_1
            end
        end
    end

    // Grant decode
    always_comb begin
        video_grant = 1'b0;
        cpu_grant   = 1'b0;
        spi1_grant  = 1'b0;
        case (slot)
            SLOT_VIDEO_1, SLOT_VIDEO_2, SLOT_VIDEO_3, SLOT_VIDEO_4: video_grant = 1'b1;
            SLOT_CPU_1, SLOT_CPU_2:                                 cpu_grant   = 1'b1;
            default:                                                spi1_grant  = 1'b1;
        endcase
    end

    assign wbc_sel        = spi1_grant;                             // 1 = SPI, 0 = video
    assign wb_en          = clk8_en_delay & (video_grant | spi1_grant);
    assign cpu_grant_en_o = clk8_en_delay & cpu_grant;

    wb_demux u_demux (
        .wb_clock_i   (wb_clock_i),
        .arst_n_i     (arst_n_i),
        .wbc_cycle_i  ({spi1_cycle_i,  video_cycle_i}),
        .wbc_strobe_i ({spi1_strobe_i, video_strobe_i}),
        .wbc_addr_i   ({spi1_addr_i,   video_addr_i}),
        .wbc_dout_i   ({spi1_dout_i,   video_dout_i}),
        .wbc_we_i     ({spi1_we_i,     video_we_i}),
        .wbc_din_o    ({spi1_din_o,    video_din_o}),
        .wbc_stall_o  ({spi1_stall_o,  video_stall_o}),
        .wbc_ack_o    ({spi1_ack_o,    video_ack_o}),
        .wb_cycle_o   (wb_cycle_o),
        .wb_strobe_o  (wb_strobe_o),
        .wb_addr_o    (wb_addr_o),
        .wb_dout_o    (wb_dout_o),
        .wb_we_o      (wb_we_o),
        .wb_din_i     (wb_din_i),
        .wb_stall_i   (wb_stall_i),
        .wb_ack_i     (wb_ack_i),
        .wbc_sel_i    (wbc_sel),
        .wb_en_i      (wb_en)
    );

endmodule

`default_nettype wire

// File: verilog/wb_demux.sv
// Two-controller Wishbone demux with request routing and owner-steered ack and read data
`timescale 1ns/1ns
`default_nettype none

module wb_demux (
    input  logic                            wb_clock_i,
    input  logic                            arst_n_i,

    // Controller side, index 1 = SPI, index 0 = video
    input  logic                 [1:0]      wbc_cycle_i,
    input  logic                 [1:0]      wbc_strobe_i,
    input  common_pkg::wb_addr_t [1:0]      wbc_addr_i,
    input  common_pkg::data_t    [1:0]      wbc_dout_i,
    input  logic                 [1:0]      wbc_we_i,
    output common_pkg::data_t    [1:0]      wbc_din_o,
    output logic                 [1:0]      wbc_stall_o,
    output logic                 [1:0]      wbc_ack_o,

    // Bus side
    output logic                            wb_cycle_o,
    output logic                            wb_strobe_o,
    output common_pkg::wb_addr_t            wb_addr_o,
    output common_pkg::data_t               wb_dout_o,
    output logic                            wb_we_o,
    input  common_pkg::data_t               wb_din_i,
    input  logic                            wb_stall_i,
    input  logic                            wb_ack_i,

    // Control from the arbiter
    input  logic                            wbc_sel_i,   // Controller that owns the window
    input  logic                            wb_en_i      // Window open
);

    logic accept;
    logic owner;           // Controller of the request waiting for its ack

    // Request path follows the selected controller
    assign wb_cycle_o  = wb_en_i & wbc_cycle_i[wbc_sel_i];
    assign wb_strobe_o = wb_en_i & wbc_strobe_i[wbc_sel_i];
    assign wb_addr_o   = wbc_addr_i[wbc_sel_i];
    assign wb_dout_o   = wbc_dout_i[wbc_sel_i];
    assign wb_we_o     = wbc_we_i[wbc_sel_i];

    assign accept = wb_cycle_o & wb_strobe_o & ~wb_stall_i;

    // Target acks exactly one cycle after acceptance, so one owner bit is enough
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            owner <= 1'b0;
        end else if (accept) begin
            owner <= wbc_sel_i;
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            // Only the window owner sees the bus stall, the other one waits
            wbc_stall_o[i] = ~(wb_en_i & (wbc_sel_i == 1'(i))) | wb_stall_i;

            // Ack and data go back to the owner, even after the window closed
            wbc_ack_o[i]   = wb_ack_i & (owner == 1'(i));
            wbc_din_o[i]   = (owner == 1'(i)) ? wb_din_i : '0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/wb_sram_target.sv
// Pipelined Wishbone byte RAM target with programmable wait states
`timescale 1ns/1ns
`default_nettype none

module wb_sram_target #(
    parameter int WAIT_STATES   = 1,      // Stall cycles after every access
    parameter int MEM_ADDR_BITS = 10      // RAM holds 2**MEM_ADDR_BITS bytes
) (
    input  logic                  wb_clock_i,
    input  logic                  arst_n_i,

    input  logic                  wb_cycle_i,
    input  logic                  wb_strobe_i,
    input  common_pkg::wb_addr_t  wb_addr_i,
    input  common_pkg::data_t     wb_dout_i,   // Write data from the controller
    input  logic                  wb_we_i,

    output common_pkg::data_t     wb_din_o,    // Read data back to the controller
    output logic                  wb_stall_o,
    output logic                  wb_ack_o
);
    import common_pkg::*;

    localparam int MEM_WORDS = 2 ** MEM_ADDR_BITS;
    localparam int WAIT_BITS = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
    localparam logic [WAIT_BITS-1:0] WAIT_LOAD = WAIT_BITS'(WAIT_STATES);

    data_t                 mem [MEM_WORDS];
    logic [WAIT_BITS-1:0]  wait_cnt;
    logic                  accept;
    logic [MEM_ADDR_BITS-1:0] mem_idx;

    assign accept     = wb_cycle_i & wb_strobe_i & ~wb_stall_o;
    assign mem_idx    = wb_addr_i[MEM_ADDR_BITS-1:0];   // Upper address bits ignored
    assign wb_stall_o = (wait_cnt != '0);

    // Storage and read data
    always_ff @(posedge wb_clock_i) begin
        if (accept) begin
            if (wb_we_i) begin
                mem[mem_idx] <= wb_dout_i;
            end
            wb_din_o <= mem[mem_idx];
        end
    end

    // Ack one cycle after acceptance
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= accept;
        end
    end

    // Wait-state down-counter
    always_ff @(posedge wb_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wait_cnt <= '0;
        end else if (accept) begin
            wait_cnt <= WAIT_LOAD;
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/common_pkg.sv
// Bus widths, address and data vector types, slot wheel enum
`default_nettype none

package common_pkg;

    // Wishbone word address and data byte widths
    parameter int WB_ADDR_WIDTH = 17;
    parameter int DATA_WIDTH    = 8;

    // Address as seen by every controller and the RAM target
    typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;

    // One data byte on the bus
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Positions of the eight-slot time wheel, in rotation order.
    // Video owns four slots, the CPU two and the SPI bridge two.
    typedef enum logic [2:0] {
        SLOT_VIDEO_1 = 3'd0,
        SLOT_VIDEO_2 = 3'd1,
        SLOT_VIDEO_3 = 3'd2,
        SLOT_VIDEO_4 = 3'd3,
        SLOT_CPU_1   = 3'd4,
        SLOT_CPU_2   = 3'd5,
        SLOT_SPI_1   = 3'd6,
        SLOT_SPI_2   = 3'd7   // Reset value, so the first pulse lands on video
    } slot_e;

endpackage

`default_nettype wire
